/* mini_pipe_cfg.svh */
`ifndef MINI_PIPE_CFG_SVH
`define MINI_PIPE_CFG_SVH

// Register file geometry.
`define REG_FILE_ADDR_WIDTH 5
`define REG_FILE_DEPTH      (1 << `REG_FILE_ADDR_WIDTH)

// Datapath word width.
`define DATA_WIDTH 32

// Data memory is word addressed, and addresses wrap modulo the depth.
`define DMEM_ADDR_WIDTH 4
`define DMEM_DEPTH      (1 << `DMEM_ADDR_WIDTH)

// Bypass select width and codes.
`define FORW_SEL_WIDTH   2
`define FORW_SEL_INPUT   2'd0 // value read from the register file at issue.
`define FORW_SEL_ALU_RES 2'd1 // result held in the EX/MEM register.
`define FORW_SEL_MEM_RES 2'd2 // result held in the MEM/WB register.

`endif

/* mini_pipe_pkg.sv */
`include "mini_pipe_cfg.svh"

package mini_pipe_pkg;

    // register index, wide enough for the whole register file.
    typedef logic [`REG_FILE_ADDR_WIDTH - 1:0] reg_idx_t;

    // One datapath word.
    typedef logic [`DATA_WIDTH - 1:0] word_t;

    // bypass select for one operand.
    typedef logic [`FORW_SEL_WIDTH - 1:0] fwd_sel_t;

    // Decoded operation as delivered by the external issuer.
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_ADDI = 4'd6, // rs1 plus the immediate.
        OP_LW   = 4'd7, // loads from rs1 plus the immediate.
        OP_SW   = 4'd8  // stores register rd to rs1 plus the immediate.
    } op_t;

endpackage

/* reg_file.sv */
`include "mini_pipe_cfg.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mini_pipe_pkg::reg_idx_t rd_addr_a,
    input  mini_pipe_pkg::reg_idx_t rd_addr_b,
    input  mini_pipe_pkg::reg_idx_t rd_addr_c,
    input  logic                    wr_en,
    input  mini_pipe_pkg::reg_idx_t wr_addr,
    input  mini_pipe_pkg::word_t    wr_data,
    output mini_pipe_pkg::word_t    rd_data_a,
    output mini_pipe_pkg::word_t    rd_data_b,
    output mini_pipe_pkg::word_t    rd_data_c
);
    import mini_pipe_pkg::*;

    word_t regs [`REG_FILE_DEPTH];

    // register 0 is hardwired to zero, and a same-cycle write is passed straight through.
    function automatic word_t read_port(input reg_idx_t addr, input logic we,
                                        input reg_idx_t waddr, input word_t wdata,
                                        input word_t stored);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (we && (waddr == addr)) begin
            val = wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    assign rd_data_a = read_port(rd_addr_a, wr_en, wr_addr, wr_data, regs[rd_addr_a]);
    assign rd_data_b = read_port(rd_addr_b, wr_en, wr_addr, wr_data, regs[rd_addr_b]);
    assign rd_data_c = read_port(rd_addr_c, wr_en, wr_addr, wr_data, regs[rd_addr_c]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_FILE_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin // writes to r0 are dropped.
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

/* forwarding_unit.sv */
`include "mini_pipe_cfg.svh"

module forwarding_unit (
    input  mini_pipe_pkg::reg_idx_t ex_reg_1_idx,
    input  mini_pipe_pkg::reg_idx_t ex_reg_2_idx,
    input  mini_pipe_pkg::reg_idx_t ex_reg_dest_idx,

    input  logic                    mem_wb_en,
    input  logic                    mem_no_op,
    input  mini_pipe_pkg::reg_idx_t mem_reg_dest_idx,

    input  logic                    wb_wb_en,
    input  logic                    wb_no_op,
    input  mini_pipe_pkg::reg_idx_t wb_reg_dest_idx,

    output mini_pipe_pkg::fwd_sel_t operand_1_select,
    output mini_pipe_pkg::fwd_sel_t operand_2_select,
    output mini_pipe_pkg::fwd_sel_t store_data_select
);
    import mini_pipe_pkg::*;

    logic mem_valid;
    logic wb_valid;

    // A stage can only supply a value if it really writes a nonzero register.
    assign mem_valid = ~mem_no_op & mem_wb_en & (mem_reg_dest_idx != '0);
    assign wb_valid  = ~wb_no_op & wb_wb_en & (wb_reg_dest_idx != '0);

    // the MEM stage holds the younger producer, so it is checked first.
    function automatic fwd_sel_t pick_source(input reg_idx_t idx,
                                             input logic mem_ok, input reg_idx_t mem_dest,
                                             input logic wb_ok, input reg_idx_t wb_dest);
        fwd_sel_t sel;
        casez ({mem_ok && (idx == mem_dest), wb_ok && (idx == wb_dest)})
            2'b1?:   sel = `FORW_SEL_ALU_RES;
            2'b01:   sel = `FORW_SEL_MEM_RES;
            default: sel = `FORW_SEL_INPUT;
        endcase
        return sel;
    endfunction

    assign operand_1_select  = pick_source(ex_reg_1_idx, mem_valid, mem_reg_dest_idx,
                                           wb_valid, wb_reg_dest_idx);
    assign operand_2_select  = pick_source(ex_reg_2_idx, mem_valid, mem_reg_dest_idx,
                                           wb_valid, wb_reg_dest_idx);
    // store data is named by the destination field of a store.
    assign store_data_select = pick_source(ex_reg_dest_idx, mem_valid, mem_reg_dest_idx,
                                           wb_valid, wb_reg_dest_idx);

endmodule

/* execute_stage.sv */
`include "mini_pipe_cfg.svh"

module execute_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  mini_pipe_pkg::op_t      issue_op,
    input  mini_pipe_pkg::reg_idx_t issue_rs1,
    input  mini_pipe_pkg::reg_idx_t issue_rs2,
    input  mini_pipe_pkg::reg_idx_t issue_rd,
    input  mini_pipe_pkg::word_t    issue_imm,
    input  mini_pipe_pkg::word_t    rf_data_1,
    input  mini_pipe_pkg::word_t    rf_data_2,
    input  mini_pipe_pkg::word_t    rf_data_st,
    input  mini_pipe_pkg::fwd_sel_t operand_1_select,
    input  mini_pipe_pkg::fwd_sel_t operand_2_select,
    input  mini_pipe_pkg::fwd_sel_t store_data_select,
    input  mini_pipe_pkg::word_t    wb_result,
    output mini_pipe_pkg::reg_idx_t ex_reg_1_idx,
    output mini_pipe_pkg::reg_idx_t ex_reg_2_idx,
    output mini_pipe_pkg::reg_idx_t ex_reg_dest_idx,
    output mini_pipe_pkg::op_t      mem_op,
    output logic                    mem_wb_en,
    output logic                    mem_no_op,
    output mini_pipe_pkg::reg_idx_t mem_reg_dest_idx,
    output mini_pipe_pkg::word_t    mem_alu_res,
    output mini_pipe_pkg::word_t    mem_store_data
);
    import mini_pipe_pkg::*;

    logic  ex_valid;
    op_t   ex_op;
    word_t ex_imm;
    word_t ex_rf_data_1;
    word_t ex_rf_data_2;
    word_t ex_rf_data_st;
    word_t operand_1;
    word_t operand_2;
    word_t store_data;
    word_t alu_res;
    logic  writes_reg;

    function automatic word_t select_operand(input fwd_sel_t sel, input word_t rf_val,
                                             input word_t alu_val, input word_t wb_val);
        word_t val;
        case (sel)
            `FORW_SEL_ALU_RES: val = alu_val;
            `FORW_SEL_MEM_RES: val = wb_val;
            default:           val = rf_val;
        endcase
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= issue_valid; // a low issue_valid turns into a bubble.
        end
    end

    always_ff @(posedge clk) begin
        ex_op           <= issue_op;
        ex_reg_1_idx    <= issue_rs1;
        ex_reg_2_idx    <= issue_rs2;
        ex_reg_dest_idx <= issue_rd;
        ex_imm          <= issue_imm;
        ex_rf_data_1    <= rf_data_1;
        ex_rf_data_2    <= rf_data_2;
        ex_rf_data_st   <= rf_data_st;
    end

    assign operand_1  = select_operand(operand_1_select, ex_rf_data_1, mem_alu_res, wb_result);
    assign operand_2  = select_operand(operand_2_select, ex_rf_data_2, mem_alu_res, wb_result);
    assign store_data = select_operand(store_data_select, ex_rf_data_st, mem_alu_res, wb_result);

    always_comb begin
        case (ex_op)
            OP_ADD:                alu_res = operand_1 + operand_2;
            OP_SUB:                alu_res = operand_1 - operand_2;
            OP_AND:                alu_res = operand_1 & operand_2;
            OP_OR:                 alu_res = operand_1 | operand_2;
            OP_XOR:                alu_res = operand_1 ^ operand_2;
            OP_ADDI, OP_LW, OP_SW: alu_res = operand_1 + ex_imm; // address or sum.
            default:               alu_res = '0;
        endcase
    end

    // Writes to r0 never reach the retire port, so they are not flagged as writes.
    always_comb begin
        case (ex_op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW:
                writes_reg = ex_valid && (ex_reg_dest_idx != '0);
            default:
                writes_reg = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_op    <= OP_NOP;
            mem_wb_en <= 1'b0;
            mem_no_op <= 1'b1;
        end else begin
            mem_op    <= ex_valid ? ex_op : OP_NOP; // bubbles never touch memory.
            mem_wb_en <= writes_reg;
            mem_no_op <= !ex_valid || (ex_op == OP_NOP);
        end
    end

    always_ff @(posedge clk) begin
        mem_reg_dest_idx <= ex_reg_dest_idx;
        mem_alu_res      <= alu_res;
        mem_store_data   <= store_data;
    end

endmodule

/* memory_stage.sv */
`include "mini_pipe_cfg.svh"

module memory_stage (
    input  logic                    clk,
    input  logic                    rst_n,
    input  mini_pipe_pkg::op_t      mem_op,
    input  logic                    mem_wb_en,
    input  logic                    mem_no_op,
    input  mini_pipe_pkg::reg_idx_t mem_reg_dest_idx,
    input  mini_pipe_pkg::word_t    mem_alu_res,
    input  mini_pipe_pkg::word_t    mem_store_data,
    output logic                    wb_wb_en,
    output logic                    wb_no_op,
    output mini_pipe_pkg::reg_idx_t wb_reg_dest_idx,
    output mini_pipe_pkg::word_t    wb_result
);
    import mini_pipe_pkg::*;

    word_t                       dmem [`DMEM_DEPTH];
    logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr;
    word_t                       load_data;
    word_t                       stage_result;

    // only the low address bits are decoded, so addresses wrap around.
    assign dmem_addr    = mem_alu_res[`DMEM_ADDR_WIDTH-1:0];
    assign load_data    = dmem[dmem_addr];
    assign stage_result = (mem_op == OP_LW) ? load_data : mem_alu_res;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_op == OP_SW) begin
            dmem[dmem_addr] <= mem_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_wb_en <= 1'b0;
            wb_no_op <= 1'b1; // the WB stage starts out empty.
        end else begin
            wb_wb_en <= mem_wb_en;
            wb_no_op <= mem_no_op;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg_dest_idx <= mem_reg_dest_idx;
        wb_result       <= stage_result;
    end

endmodule

/* mini_pipe_top.sv */
module mini_pipe_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    issue_valid,
    input  mini_pipe_pkg::op_t      issue_op,
    input  mini_pipe_pkg::reg_idx_t issue_rs1,
    input  mini_pipe_pkg::reg_idx_t issue_rs2,
    input  mini_pipe_pkg::reg_idx_t issue_rd,
    input  mini_pipe_pkg::word_t    issue_imm,
    output logic                    retire_valid,
    output mini_pipe_pkg::reg_idx_t retire_rd,
    output mini_pipe_pkg::word_t    retire_data
);
    import mini_pipe_pkg::*;

    word_t    rf_data_1;
    word_t    rf_data_2;
    word_t    rf_data_st;
    reg_idx_t ex_reg_1_idx;
    reg_idx_t ex_reg_2_idx;
    reg_idx_t ex_reg_dest_idx;
    fwd_sel_t operand_1_select;
    fwd_sel_t operand_2_select;
    fwd_sel_t store_data_select;
    op_t      mem_op;
    logic     mem_wb_en;
    logic     mem_no_op;
    reg_idx_t mem_reg_dest_idx;
    word_t    mem_alu_res;
    word_t    mem_store_data;
    logic     wb_wb_en;
    logic     wb_no_op;
    reg_idx_t wb_reg_dest_idx;
    word_t    wb_result;

    // the retire strobe doubles as the register file write enable.
    assign retire_valid = wb_wb_en & ~wb_no_op;
    assign retire_rd    = wb_reg_dest_idx;
    assign retire_data  = wb_result;

    reg_file reg_file_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (issue_rs1),
        .rd_addr_b (issue_rs2),
        .rd_addr_c (issue_rd),  // store data is read on the destination index.
        .wr_en     (retire_valid),
        .wr_addr   (wb_reg_dest_idx),
        .wr_data   (wb_result),
        .rd_data_a (rf_data_1),
        .rd_data_b (rf_data_2),
        .rd_data_c (rf_data_st)
    );

    forwarding_unit forwarding_unit_i (
        .ex_reg_1_idx      (ex_reg_1_idx),
        .ex_reg_2_idx      (ex_reg_2_idx),
        .ex_reg_dest_idx   (ex_reg_dest_idx),
        .mem_wb_en         (mem_wb_en),
        .mem_no_op         (mem_no_op),
        .mem_reg_dest_idx  (mem_reg_dest_idx),
        .wb_wb_en          (wb_wb_en),
        .wb_no_op          (wb_no_op),
        .wb_reg_dest_idx   (wb_reg_dest_idx),
        .operand_1_select  (operand_1_select),
        .operand_2_select  (operand_2_select),
        .store_data_select (store_data_select)
    );

    execute_stage execute_stage_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .issue_valid       (issue_valid),
        .issue_op          (issue_op),
        .issue_rs1         (issue_rs1),
        .issue_rs2         (issue_rs2),
        .issue_rd          (issue_rd),
        .issue_imm         (issue_imm),
        .rf_data_1         (rf_data_1),
        .rf_data_2         (rf_data_2),
        .rf_data_st        (rf_data_st),
        .operand_1_select  (operand_1_select),
        .operand_2_select  (operand_2_select),
        .store_data_select (store_data_select),
        .wb_result         (wb_result),
        .ex_reg_1_idx      (ex_reg_1_idx),
        .ex_reg_2_idx      (ex_reg_2_idx),
        .ex_reg_dest_idx   (ex_reg_dest_idx),
        .mem_op            (mem_op),
        .mem_wb_en         (mem_wb_en),
        .mem_no_op         (mem_no_op),
        .mem_reg_dest_idx  (mem_reg_dest_idx),
        .mem_alu_res       (mem_alu_res),
        .mem_store_data    (mem_store_data)
    );

    memory_stage memory_stage_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .mem_op           (mem_op),
        .mem_wb_en        (mem_wb_en),
        .mem_no_op        (mem_no_op),
        .mem_reg_dest_idx (mem_reg_dest_idx),
        .mem_alu_res      (mem_alu_res),
        .mem_store_data   (mem_store_data),
        .wb_wb_en         (wb_wb_en),
        .wb_no_op         (wb_no_op),
        .wb_reg_dest_idx  (wb_reg_dest_idx),
        .wb_result        (wb_result)
    );

endmodule

/* mini_pipe_props.sv */
module mini_pipe_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    issue_valid,
    input mini_pipe_pkg::op_t      issue_op,
    input mini_pipe_pkg::reg_idx_t issue_rs1,
    input mini_pipe_pkg::reg_idx_t issue_rs2,
    input mini_pipe_pkg::reg_idx_t issue_rd,
    input logic                    retire_valid
);
    import mini_pipe_pkg::*;

    logic writing_issue;
    logic load_issue;

    // true when an instruction of this kind reads register idx as a source.
    function automatic logic reads_index(input op_t op, input reg_idx_t rs1,
                                         input reg_idx_t rs2, input reg_idx_t rd,
                                         input reg_idx_t idx);
        logic hit;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: hit = (rs1 == idx) || (rs2 == idx);
            OP_ADDI, OP_LW:                        hit = (rs1 == idx);
            OP_SW:                                 hit = (rs1 == idx) || (rd == idx);
            default:                               hit = 1'b0;
        endcase
        return hit;
    endfunction

    assign writing_issue = issue_valid && (issue_rd != '0) &&
                           (issue_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                             OP_ADDI, OP_LW});
    assign load_issue    = issue_valid && (issue_op == OP_LW) && (issue_rd != '0);

    retire_latency: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid == $past(writing_issue, 3))
        else $error("retire strobe does not follow a writing issue by three cycles");

    // The load data is not ready in time for the very next instruction.
    load_use_rule: assert property (@(posedge clk) disable iff (!rst_n)
        $past(load_issue) |-> !(issue_valid && reads_index(issue_op, issue_rs1, issue_rs2,
                                                           issue_rd, $past(issue_rd))))
        else $error("instruction reads the destination of the load issued just before it");

    retire_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !retire_valid)
        else $error("retire strobe is high in the first cycle after reset");

endmodule

bind mini_pipe_top mini_pipe_props mini_pipe_props_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_op     (issue_op),
    .issue_rs1    (issue_rs1),
    .issue_rs2    (issue_rs2),
    .issue_rd     (issue_rd),
    .retire_valid (retire_valid)
);

/* mini_pipe_tb.sv */
`include "mini_pipe_cfg.svh"

module mini_pipe_tb;
    import mini_pipe_pkg::*;

    localparam int          CLK_PERIOD      = 40;
    localparam int unsigned RAND_SEED       = 32'h5a65_c978;
    localparam int          RESET_CYCLES    = 2;
    localparam int          DIRECTED_CYCLES = 43 + 20 + 21 + 11 + 15; // directed tests with drains.
    localparam int          RANDOM_COUNT    = 300;
    localparam int          TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_COUNT + 3;
    localparam int          WATCHDOG_TIME   = (TOTAL_CYCLES + 20) * CLK_PERIOD * 2;

    logic     clk;
    logic     rst_n;
    logic     issue_valid;
    op_t      issue_op;
    reg_idx_t issue_rs1;
    reg_idx_t issue_rs2;
    reg_idx_t issue_rd;
    word_t    issue_imm;
    logic     retire_valid;
    reg_idx_t retire_rd;
    word_t    retire_data;

    word_t    model_regs [`REG_FILE_DEPTH];
    word_t    model_mem [`DMEM_DEPTH];
    int       cycle;
    int       exp_due [$]; // falling edge at which each record must show on the retire port.
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];

    mini_pipe_top mini_pipe_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_rs1    (issue_rs1),
        .issue_rs2    (issue_rs2),
        .issue_rd     (issue_rd),
        .issue_imm    (issue_imm),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        report_failure("Timeout: the run did not finish in the expected time");
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic word_t reg_value(input reg_idx_t idx);
        return (idx == '0) ? '0 : model_regs[idx]; // r0 always reads zero.
    endfunction

    // true when an instruction of this kind reads register idx as a source.
    function automatic logic reads_index(input op_t op, input reg_idx_t rs1, input reg_idx_t rs2,
                                         input reg_idx_t rd, input reg_idx_t idx);
        logic hit;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: hit = (rs1 == idx) || (rs2 == idx);
            OP_ADDI, OP_LW:                        hit = (rs1 == idx);
            OP_SW:                                 hit = (rs1 == idx) || (rd == idx);
            default:                               hit = 1'b0;
        endcase
        return hit;
    endfunction

    function automatic op_t pick_op(input int unsigned n);
        op_t op;
        case (n)
            1:       op = OP_ADD;
            2:       op = OP_SUB;
            3:       op = OP_AND;
            4:       op = OP_OR;
            5:       op = OP_XOR;
            6:       op = OP_ADDI;
            7:       op = OP_LW;
            8:       op = OP_SW;
            default: op = OP_NOP;
        endcase
        return op;
    endfunction

    // Executes one instruction in program order and queues its retire record.
    task automatic apply_model(input op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                               input reg_idx_t rs2, input word_t imm);
        word_t                       a;
        word_t                       b;
        word_t                       ea;
        word_t                       res;
        logic [`DMEM_ADDR_WIDTH-1:0] addr;
        logic                        writes;
        a      = reg_value(rs1);
        b      = reg_value(rs2);
        ea     = a + imm;
        addr   = ea[`DMEM_ADDR_WIDTH-1:0]; // the memory wraps modulo its depth.
        res    = '0;
        writes = 1'b1;
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = ea;
            OP_LW:   res = model_mem[addr];
            OP_SW: begin
                model_mem[addr] = reg_value(rd); // store data comes from the rd field.
                writes          = 1'b0;
            end
            default: writes = 1'b0;
        endcase
        if (writes && (rd != '0)) begin
            model_regs[rd] = res;
            exp_due.push_back(cycle + 3);
            exp_rd.push_back(rd);
            exp_data.push_back(res);
        end
    endtask

    task automatic check_retire();
        if ((exp_due.size() > 0) && (exp_due[0] == cycle)) begin
            assert (retire_valid === 1'b1) else
                report_failure($sformatf("Mismatch retire_valid: expected 1, got %h",
                                         retire_valid));
            assert (retire_rd === exp_rd[0]) else
                report_failure($sformatf("Mismatch retire_rd: expected %h, got %h",
                                         exp_rd[0], retire_rd));
            assert (retire_data === exp_data[0]) else
                report_failure($sformatf("Mismatch retire_data: expected %h, got %h",
                                         exp_data[0], retire_data));
            exp_due.delete(0);
            exp_rd.delete(0);
            exp_data.delete(0);
        end else begin
            assert (retire_valid === 1'b0) else
                report_failure($sformatf("Mismatch retire_valid: expected 0, got %h",
                                         retire_valid));
        end
    endtask

    task automatic drive_cycle(input logic valid, input op_t op, input reg_idx_t rd,
                               input reg_idx_t rs1, input reg_idx_t rs2, input word_t imm);
        @(negedge clk);
        cycle++;
        check_retire(); // outputs are stable halfway between rising edges.
        issue_valid = valid;
        issue_op    = op;
        issue_rd    = rd;
        issue_rs1   = rs1;
        issue_rs2   = rs2;
        issue_imm   = imm;
        if (valid) begin
            apply_model(op, rd, rs1, rs2, imm);
        end
    endtask

    task automatic issue_instr(input op_t op, input reg_idx_t rd, input reg_idx_t rs1,
                               input reg_idx_t rs2, input word_t imm);
        drive_cycle(1'b1, op, rd, rs1, rs2, imm);
    endtask

    task automatic issue_bubble();
        drive_cycle(1'b0, OP_NOP, '0, '0, '0, '0);
    endtask

    task automatic drain_pipeline();
        repeat (3) issue_bubble();
    endtask

    task automatic check_reset_state();
        repeat (8) issue_bubble();
        for (int r = 0; r < `REG_FILE_DEPTH; r++) begin
            issue_instr(OP_ADD, reg_idx_t'(r), reg_idx_t'(r), 5'd0, '0);
        end
        drain_pipeline();
    endtask

    task automatic run_independent_ops();
        for (int r = 1; r <= 8; r++) begin
            issue_instr(OP_ADDI, reg_idx_t'(r), 5'd0, 5'd0, $urandom());
        end
        repeat (3) issue_bubble(); // the sources below are all in the register file.
        issue_instr(OP_ADD, 5'd9, 5'd1, 5'd2, '0);
        issue_instr(OP_SUB, 5'd10, 5'd3, 5'd4, '0);
        issue_instr(OP_AND, 5'd11, 5'd5, 5'd6, '0);
        issue_instr(OP_OR, 5'd12, 5'd7, 5'd8, '0);
        issue_instr(OP_XOR, 5'd13, 5'd1, 5'd5, '0);
        issue_instr(OP_ADDI, 5'd14, 5'd2, 5'd0, $urandom());
        drain_pipeline();
    endtask

    task automatic run_dependency_chains();
        issue_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, $urandom());
        issue_instr(OP_ADD, 5'd2, 5'd1, 5'd1, '0);         // distance 1.
        issue_instr(OP_ADDI, 5'd3, 5'd0, 5'd0, $urandom());
        issue_bubble();
        issue_instr(OP_SUB, 5'd4, 5'd3, 5'd1, '0);         // distance 2.
        issue_instr(OP_ADDI, 5'd5, 5'd0, 5'd0, $urandom());
        repeat (2) issue_bubble();
        issue_instr(OP_XOR, 5'd6, 5'd5, 5'd3, '0);         // register file write bypass.
        issue_instr(OP_ADDI, 5'd7, 5'd0, 5'd0, $urandom());
        issue_instr(OP_ADDI, 5'd7, 5'd0, 5'd0, $urandom());
        issue_instr(OP_ADD, 5'd8, 5'd0, 5'd7, '0);         // younger r7 in MEM must win.
        issue_instr(OP_OR, 5'd9, 5'd7, 5'd0, '0);
        issue_instr(OP_ADDI, 5'd10, 5'd0, 5'd0, 32'd1);
        repeat (3) issue_instr(OP_ADDI, 5'd10, 5'd10, 5'd0, 32'd1);
        issue_instr(OP_AND, 5'd11, 5'd10, 5'd10, '0);
        drain_pipeline();
    endtask

    task automatic check_r0_writes();
        issue_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, $urandom());
        issue_instr(OP_ADDI, 5'd0, 5'd1, 5'd0, $urandom()); // no retire for r0.
        issue_instr(OP_ADD, 5'd12, 5'd0, 5'd1, '0);
        issue_instr(OP_ADD, 5'd0, 5'd1, 5'd1, '0);
        issue_bubble();
        issue_instr(OP_OR, 5'd13, 5'd0, 5'd0, '0);
        issue_instr(OP_LW, 5'd0, 5'd1, 5'd0, '0);      // its address is r1, not zero.
        issue_instr(OP_XOR, 5'd14, 5'd0, 5'd1, '0);
        drain_pipeline();
    endtask

    task automatic run_store_load();
        issue_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, $urandom());
        issue_instr(OP_SW, 5'd1, 5'd0, 5'd0, 32'd4);      // data forwarded from MEM.
        issue_instr(OP_LW, 5'd2, 5'd0, 5'd0, 32'd4);
        issue_instr(OP_ADDI, 5'd3, 5'd0, 5'd0, 32'd3);
        issue_instr(OP_ADDI, 5'd4, 5'd0, 5'd0, $urandom());
        issue_bubble();
        issue_instr(OP_SW, 5'd4, 5'd3, 5'd0, 32'h10);     // address 19 wraps to 3.
        issue_instr(OP_LW, 5'd5, 5'd0, 5'd0, 32'h23);
        issue_bubble();
        issue_instr(OP_ADD, 5'd6, 5'd5, 5'd2, '0);
        issue_instr(OP_SW, 5'd6, 5'd0, 5'd0, 32'd15);
        issue_instr(OP_LW, 5'd7, 5'd3, 5'd0, 32'd12);
        drain_pipeline();
    endtask

    task automatic run_random_stream();
        logic     load_pending;
        reg_idx_t load_rd;
        op_t      op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        load_pending = 1'b0;
        load_rd      = '0;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            op  = pick_op($urandom_range(8, 0));
            rd  = reg_idx_t'($urandom_range(7, 0)); // few registers give many dependencies.
            rs1 = reg_idx_t'($urandom_range(7, 0));
            rs2 = reg_idx_t'($urandom_range(7, 0));
            imm = $urandom();
            if (($urandom_range(9, 0) == 0) ||
                (load_pending && reads_index(op, rs1, rs2, rd, load_rd))) begin
                issue_bubble();
                load_pending = 1'b0;
            end else begin
                issue_instr(op, rd, rs1, rs2, imm);
                load_pending = (op == OP_LW) && (rd != '0);
                load_rd      = rd;
            end
        end
        drain_pipeline();
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_NOP;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_rd    = '0;
        issue_imm   = '0;
        cycle       = 0;
        for (int i = 0; i < `REG_FILE_DEPTH; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_state();
        run_independent_ops();
        run_dependency_chains();
        check_r0_writes();
        run_store_load();
        run_random_stream();
        if (exp_due.size() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("Expected retire records were left unchecked at the end of the run");
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* mini_pipe.f */
+incdir+.
mini_pipe_pkg.sv
reg_file.sv
forwarding_unit.sv
execute_stage.sv
memory_stage.sv
mini_pipe_top.sv
mini_pipe_props.sv
mini_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mini_pipe.f --top-module mini_pipe_tb \
    && ./obj_dir/Vmini_pipe_tb | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
